/* include/video_settings.svh */
/*
  Raster, color PROM and host register constants for the video block.
  Counter limits are last values, so a line is VIDEO_HCNT_END+1 pixels.
  Vertical blank wraps through line 0, hence VB_START above VB_END.
*/
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Raster counter limits
`define VIDEO_HCNT_END   9'd383
`define VIDEO_VCNT_END   9'd263

// Blanking limits
`define VIDEO_HB_START   9'd255
`define VIDEO_VB_START   9'd236
`define VIDEO_VB_END     9'd19

// Object box
`define VIDEO_OBJ_SIZE   9'd16
`define VIDEO_OBJ_COLOR  4'hA

// Color PROMs, 256 x 4 each
`define VIDEO_PROM_AW    8
`define VIDEO_PROM_DEPTH 256
`define VIDEO_PROM_LAST  10'h2FF

// Host register map
`define VIDEO_WB_PAL     10'h300
`define VIDEO_WB_OBJX    10'h301
`define VIDEO_WB_OBJY    10'h302
`define VIDEO_WB_STATUS  10'h303

`endif

/* verilog/video_pkg.sv */
/*
  Shared bundles for the video block and its testbench.
  Field order is MSB first, so widths here fix the bit layout.
*/
`default_nettype none

package video_pkg;

    // Raster position and blanking flags
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
    } video_timing_t;

    // Layer pixels, zero means transparent
    typedef struct packed {
        logic [3:0] obj_pxl;
        logic [3:0] scr_pxl;
    } layer_pxl_t;

    // PROM write strobe, prog_en one-hot red/green/blue
    typedef struct packed {
        logic [2:0] prog_en;
        logic [7:0] prog_addr;
        logic [3:0] prog_data;
    } prom_wr_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Wishbone classic, host side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [9:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    // Wishbone classic, slave side
    typedef struct packed {
        logic [15:0] dat;
        logic        ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/video_timer.sv */
/*
  Raster counters for a 384 x 264 frame.
  Counts only move on pxl_cen; clk is the fast system clock.
  LHBL and LVBL are decoded straight from the counts, no pipeline.
  No sync pulses are generated.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_timer import video_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pxl_cen,
    output video_timing_t timing
);

logic [8:0] hcnt;
logic [8:0] vcnt;
logic       hwrap;
logic       vwrap;
logic       hvis;
logic       vblank;

// Last pixel of a line / last line of a frame
assign hwrap = hcnt == `VIDEO_HCNT_END;
assign vwrap = vcnt == `VIDEO_VCNT_END;

// Horizontal counter
always_ff @(posedge clk) begin
    if (!rst_n) begin
        hcnt <= '0;
    end else if (pxl_cen) begin
        if (hwrap) begin
            hcnt <= '0;
        end else begin
            hcnt <= hcnt + 9'd1;
        end
    end
end

// Vertical counter, steps once per line
always_ff @(posedge clk) begin
    if (!rst_n) begin
        vcnt <= '0;
    end else if (pxl_cen && hwrap) begin
        if (vwrap) begin
            vcnt <= '0;
        end else begin
            vcnt <= vcnt + 9'd1;
        end
    end
end

// Visible columns 0..HB_START
assign hvis = hcnt <= `VIDEO_HB_START;

// Vertical blank spans the frame wrap
// VB_START..VCNT_END, then 0..VB_END
assign vblank = (vcnt >= `VIDEO_VB_START) || (vcnt <= `VIDEO_VB_END);

// Outgoing bundle
assign timing.hdump = hcnt;
assign timing.vdump = vcnt;
assign timing.lhbl  = hvis;
assign timing.lvbl  = ~vblank;

endmodule

`default_nettype wire

/* verilog/video_layers.sv */
/*
  Stand-in for the tile and sprite engines.
  Scroll layer is a diagonal tile pattern from the raster position.
  One 16 x 16 object box at obj_x/obj_y, filled with VIDEO_OBJ_COLOR.
  The box does not wrap around the screen edges.
  One pxl_cen of latency; timing_l keeps the position aligned.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_layers import video_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pxl_cen,
    input  video_timing_t timing,
    input  logic [8:0]    obj_x,
    input  logic [8:0]    obj_y,
    output layer_pxl_t    pxl,
    output video_timing_t timing_l
);

logic [3:0] scr_nxt;
logic [8:0] hoff;
logic [8:0] voff;
logic       in_box;
logic [3:0] obj_nxt;

// Tile index sum, 16-pixel tiles on both axes
assign scr_nxt = timing.hdump[7:4] + timing.vdump[7:4];

// Offset inside the box; only meaningful when not below obj_x/obj_y
assign hoff = timing.hdump - obj_x;
assign voff = timing.vdump - obj_y;

assign in_box = (timing.hdump >= obj_x) && (hoff < `VIDEO_OBJ_SIZE) &&
                (timing.vdump >= obj_y) && (voff < `VIDEO_OBJ_SIZE);

// Transparent outside the box
assign obj_nxt = in_box ? `VIDEO_OBJ_COLOR : 4'd0;

// Pixel and position registered together
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pxl      <= '0;
        timing_l <= '0;
    end else if (pxl_cen) begin
        pxl.obj_pxl <= obj_nxt;
        pxl.scr_pxl <= scr_nxt;
        timing_l    <= timing;
    end
end

endmodule

`default_nettype wire

/* verilog/video_colmix.sv */
/*
  Layer priority and color lookup through three 256 x 4 PROMs.
  Object layer wins over scroll whenever its pixel is nonzero.
  Lookup address is {layer, pal_sel, pixel}, layer 1 for object.
  PROMs are loaded from the host and have no reset value.
  Two pxl_cen of latency; timing_dly stays aligned with rgb.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_colmix import video_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pxl_cen,
    input  logic [2:0]    pal_sel,
    input  layer_pxl_t    pxl,
    input  video_timing_t timing_l,
    input  prom_wr_t      prom_wr,
    output rgb_t          rgb,
    output video_timing_t timing_dly
);

// Index 0 red, 1 green, 2 blue
logic [3:0] prom_mem [0:2][0:`VIDEO_PROM_DEPTH-1];
logic [3:0] lut_dout [0:2];

logic                      obj_win;
logic [3:0]                win_pxl;
logic [`VIDEO_PROM_AW-1:0] lut_addr;
video_timing_t             timing_p1;
logic                      visible;

// Priority, object over scroll
assign obj_win  = pxl.obj_pxl != 4'd0;
assign win_pxl  = obj_win ? pxl.obj_pxl : pxl.scr_pxl;
assign lut_addr = {obj_win, pal_sel, win_pxl};

// Host writes, any clock, not tied to pxl_cen
always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
        if (prom_wr.prog_en[i]) begin
            prom_mem[i][prom_wr.prog_addr] <= prom_wr.prog_data;
        end
    end
end

// First stage: synchronous PROM read
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        for (int i = 0; i < 3; i++) begin
            lut_dout[i] <= prom_mem[i][lut_addr];
        end
    end
end

// Blanking flags as seen by the first stage
assign visible = timing_p1.lhbl & timing_p1.lvbl;

// Timing delay line and output register
always_ff @(posedge clk) begin
    if (!rst_n) begin
        timing_p1  <= '0;
        timing_dly <= '0;
        rgb        <= '0;
    end else if (pxl_cen) begin
        timing_p1  <= timing_l;
        timing_dly <= timing_p1;
        // Black during either blank
        if (visible) begin
            rgb.red   <= lut_dout[0];
            rgb.green <= lut_dout[1];
            rgb.blue  <= lut_dout[2];
        end else begin
            rgb <= '0;
        end
    end
end

endmodule

`default_nettype wire

/* verilog/video_wb_regs.sv */
/*
  Wishbone classic slave for the video block.
  0x000-0x2FF: PROM window, bits 9:8 pick red/green/blue. Reads give 0.
  0x300 palette, 0x301/0x302 object X/Y, 0x303 status {LVBL, V16}.
  ack is one clock long and never back to back; no wait states beyond it.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_wb_regs import video_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  wb_req_t       wb_req,
    input  video_timing_t timing,
    output wb_rsp_t       wb_rsp,
    output prom_wr_t      prom_wr,
    output logic [2:0]    pal_sel,
    output logic [8:0]    obj_x,
    output logic [8:0]    obj_y
);

logic        ack;
logic [15:0] rd_dat;
logic        access;
logic        prom_hit;
logic [2:0]  prog_en;
logic [7:0]  prog_addr;
logic [3:0]  prog_data;
logic [15:0] rd_nxt;

// New cycle only when ack is not already high
assign access   = wb_req.cyc & wb_req.stb & ~ack;
assign prom_hit = wb_req.adr <= `VIDEO_PROM_LAST;

// Read mux
always_comb begin
    case (wb_req.adr)
        `VIDEO_WB_PAL:    rd_nxt = {13'd0, pal_sel};
        `VIDEO_WB_OBJX:   rd_nxt = {7'd0, obj_x};
        `VIDEO_WB_OBJY:   rd_nxt = {7'd0, obj_y};
        `VIDEO_WB_STATUS: rd_nxt = {14'd0, timing.lvbl, timing.vdump[4]};
        default:          rd_nxt = 16'd0;
    endcase
end

// Handshake, registers and PROM strobe
always_ff @(posedge clk) begin
    if (!rst_n) begin
        ack     <= 1'b0;
        prog_en <= '0;
        pal_sel <= '0;
        obj_x   <= '0;
        obj_y   <= '0;
    end else begin
        ack     <= access;
        // One-clock strobe, one color at a time
        prog_en <= (access && wb_req.we && prom_hit) ? 3'b001 << wb_req.adr[9:8] : 3'b000;
        if (access && wb_req.we) begin
            case (wb_req.adr)
                `VIDEO_WB_PAL:  pal_sel <= wb_req.dat[2:0];
                `VIDEO_WB_OBJX: obj_x   <= wb_req.dat[8:0];
                `VIDEO_WB_OBJY: obj_y   <= wb_req.dat[8:0];
                default: ;
            endcase
        end
    end
end

// Payload, qualified by prog_en / ack
always_ff @(posedge clk) begin
    if (access) begin
        prog_addr <= wb_req.adr[7:0];
        prog_data <= wb_req.dat[3:0];
        rd_dat    <= rd_nxt;
    end
end

assign prom_wr.prog_en   = prog_en;
assign prom_wr.prog_addr = prog_addr;
assign prom_wr.prog_data = prog_data;

assign wb_rsp.dat = rd_dat;
assign wb_rsp.ack = ack;

endmodule

`default_nettype wire

/* verilog/video_top.sv */
/*
  Video subsystem top: raster timer, layers, color mixer, host slave.
  rgb and timing_dly trail the raster counters by three pxl_cen.
  Host bus runs on clk with no relation to pxl_cen.
*/
`timescale 1ns/1ps
`default_nettype none

module video_top import video_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pxl_cen,
    input  wb_req_t       wb_req,
    output wb_rsp_t       wb_rsp,
    output rgb_t          rgb,
    output video_timing_t timing_dly
);

video_timing_t timing;
video_timing_t timing_l;
layer_pxl_t    pxl;
prom_wr_t      prom_wr;
logic [2:0]    pal_sel;
logic [8:0]    obj_x;
logic [8:0]    obj_y;

// Raster counters
video_timer u_timer(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .timing     ( timing     )
);

// Scroll and object pixels, one pixel behind
video_layers u_layers(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .timing     ( timing     ),
    .obj_x      ( obj_x      ),
    .obj_y      ( obj_y      ),
    .pxl        ( pxl        ),
    .timing_l   ( timing_l   )
);

// Priority, PROM lookup and blanking
video_colmix u_colmix(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .pal_sel    ( pal_sel    ),
    .pxl        ( pxl        ),
    .timing_l   ( timing_l   ),
    .prom_wr    ( prom_wr    ),
    .rgb        ( rgb        ),
    .timing_dly ( timing_dly )
);

// Host access
video_wb_regs u_wb_regs(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .wb_req     ( wb_req     ),
    .timing     ( timing     ),
    .wb_rsp     ( wb_rsp     ),
    .prom_wr    ( prom_wr    ),
    .pal_sel    ( pal_sel    ),
    .obj_x      ( obj_x      ),
    .obj_y      ( obj_y      )
);

endmodule

`default_nettype wire

/* tests/video_clkgen.sv */
/*
  Testbench clock and reset for the video block.
  10 ns clock, rst_n low for the first 3 rising edges.
  pxl_cen is high on every second clock, driven 1 ns after the edge.
*/
`timescale 1ns/1ps
`default_nettype none

module video_clkgen (
    output logic clk,
    output logic rst_n,
    output logic pxl_cen
);

initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    pxl_cen = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
end

always #5 clk = ~clk;

// Half-rate pixel enable
always @(posedge clk) begin
    #1 pxl_cen = ~pxl_cen;
end

endmodule

`default_nettype wire

/* tests/video_assertions.sv */
/*
  Concurrent checks bound into video_top.
  Color checks read video_tb.prom_ref and wait for the PROMs to be loaded.
  Colors are only checked once palette, object and PROMs have been quiet
  long enough for the pipeline to drain.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_assertions import video_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          pxl_cen,
    input wb_req_t       wb_req,
    input wb_rsp_t       wb_rsp,
    input rgb_t          rgb,
    input video_timing_t timing_dly,
    input prom_wr_t      prom_wr,
    input logic [2:0]    pal_sel,
    input logic [8:0]    obj_x,
    input logic [8:0]    obj_y
);

int            err_count = 0;
logic [2:0]    pcnt;
logic [4:0]    quiet;
logic [20:0]   cfg_q;
logic [2:0]    pal_model;
video_timing_t dly_q;
logic [1:0]    exp_status;
logic          in_box;
logic          vis;
logic          ready;
rgb_t          exp_rgb;
logic [8:0]    hoff;
logic [8:0]    voff;
logic [7:0]    addr;

// Position three pixels ahead, with raster wrap
function automatic logic [1:0] status_of(video_timing_t t);
    logic [8:0] h;
    logic [8:0] v;
    h = t.hdump;
    v = t.vdump;
    for (int i = 0; i < 3; i++) begin
        if (h == 9'd383) begin
            h = 9'd0;
            v = (v == 9'd263) ? 9'd0 : v + 9'd1;
        end else begin
            h = h + 9'd1;
        end
    end
    return {~((v >= 9'd236) || (v <= 9'd19)), v[4]};
endfunction

// Pipeline fill, quiet time and host-side palette model
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pcnt      <= '0;
        quiet     <= '0;
        cfg_q     <= '0;
        pal_model <= '0;
    end else begin
        if (pxl_cen && pcnt != 3'd4) pcnt <= pcnt + 3'd1;
        cfg_q <= {pal_sel, obj_x, obj_y};
        if (cfg_q != {pal_sel, obj_x, obj_y} || prom_wr.prog_en != 3'd0) begin
            quiet <= '0;
        end else if (quiet != 5'd16) begin
            quiet <= quiet + 5'd1;
        end
        if (wb_rsp.ack && wb_req.we && wb_req.adr == `VIDEO_WB_PAL) begin
            pal_model <= wb_req.dat[2:0];
        end
    end
    dly_q <= timing_dly;
end

// Expected color for the current delayed position
always_comb begin
    hoff       = timing_dly.hdump - obj_x;
    voff       = timing_dly.vdump - obj_y;
    in_box     = (timing_dly.hdump >= obj_x) && (hoff < 9'd16) &&
                 (timing_dly.vdump >= obj_y) && (voff < 9'd16);
    addr       = in_box ? {1'b1, pal_sel, `VIDEO_OBJ_COLOR} :
                 {1'b0, pal_sel, timing_dly.hdump[7:4] + timing_dly.vdump[7:4]};
    exp_rgb    = {video_tb.prom_ref[0][addr], video_tb.prom_ref[1][addr],
                  video_tb.prom_ref[2][addr]};
    vis        = timing_dly.lhbl && timing_dly.lvbl;
    ready      = (pcnt == 3'd4) && (quiet == 5'd16) && video_tb.prom_loaded;
    exp_status = status_of(dly_q);
end

a_reset: assert property (@(posedge clk) !rst_n |=>
    (!wb_rsp.ack && rgb == 12'd0 && !timing_dly.lhbl && !timing_dly.lvbl))
    else begin $error("reset state not clean"); err_count++; end

a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
    else begin $error("ack high for two clocks"); err_count++; end

a_ack_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
    else begin $error("ack without cyc and stb"); err_count++; end

a_pal_read: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_rsp.ack && !wb_req.we && wb_req.adr == `VIDEO_WB_PAL) |->
    wb_rsp.dat == {13'd0, pal_model})
    else begin
        $error("[FAIL] pal_read expected %h actual %h", pal_model, wb_rsp.dat);
        err_count++;
    end

a_status_read: assert property (@(posedge clk) disable iff (!rst_n)
    (pcnt == 3'd4 && wb_rsp.ack && !wb_req.we && wb_req.adr == `VIDEO_WB_STATUS) |->
    wb_rsp.dat == {14'd0, exp_status})
    else begin
        $error("[FAIL] status_read expected %h actual %h", exp_status, wb_rsp.dat);
        err_count++;
    end

a_raster: assert property (@(posedge clk) disable iff (!rst_n) (pcnt == 3'd4) |->
    (timing_dly.hdump <= 9'd383 && timing_dly.vdump <= 9'd263 &&
     timing_dly.lhbl == (timing_dly.hdump <= 9'd255) &&
     timing_dly.lvbl == !(timing_dly.vdump >= 9'd236 || timing_dly.vdump <= 9'd19)))
    else begin $error("raster position or blanking flags out of rule"); err_count++; end

a_blank: assert property (@(posedge clk) disable iff (!rst_n) !vis |-> rgb == 12'd0)
    else begin $error("[FAIL] blanking expected 000 actual %h", rgb); err_count++; end

a_scroll: assert property (@(posedge clk) disable iff (!rst_n)
    (ready && vis && !in_box) |-> rgb == exp_rgb)
    else begin
        $error("[FAIL] scroll_color expected %h actual %h", exp_rgb, rgb);
        err_count++;
    end

a_object: assert property (@(posedge clk) disable iff (!rst_n)
    (ready && vis && in_box) |-> rgb == exp_rgb)
    else begin
        $error("[FAIL] object_color expected %h actual %h", exp_rgb, rgb);
        err_count++;
    end

endmodule

`default_nettype wire

/* tests/video_tb.sv */
/*
  Testbench for video_top.
  Fills the three color PROMs with random data through Wishbone, keeps a
  reference copy, then runs two frames with different palette and object.
  Checking lives in the bound assertion module; this bench watches its count.
*/
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_tb import video_pkg::*; ();

localparam int BUS_TIMEOUT   = 20;
localparam int FRAME_TIMEOUT = 2 * 384 * 264 * 2;

logic          clk;
logic          rst_n;
logic          pxl_cen;
wb_req_t       wb_req;
wb_rsp_t       wb_rsp;
rgb_t          rgb;
video_timing_t timing_dly;

// Reference PROM image, read by the assertion module
logic [3:0] prom_ref [0:2][0:255];
logic       prom_loaded;
logic [15:0] rd_val;
integer     seed;

video_clkgen i_clkgen (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .pxl_cen ( pxl_cen )
);

video_top i_dut (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .wb_req     ( wb_req     ),
    .wb_rsp     ( wb_rsp     ),
    .rgb        ( rgb        ),
    .timing_dly ( timing_dly )
);

bind video_top video_assertions i_chk (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .wb_req     ( wb_req     ),
    .wb_rsp     ( wb_rsp     ),
    .rgb        ( rgb        ),
    .timing_dly ( timing_dly ),
    .prom_wr    ( prom_wr    ),
    .pal_sel    ( pal_sel    ),
    .obj_x      ( obj_x      ),
    .obj_y      ( obj_y      )
);

// Stop at the first failed assertion
always @(posedge clk) begin
    if (i_dut.i_chk.err_count != 0) begin
        $display("Done: errors found");
        $fatal(1, "assertion failure in the bound checker");
    end
end

// One classic cycle, host holds the request through the ack clock
task automatic bus_cycle(input logic we, input logic [9:0] adr,
                         input logic [15:0] dat, output logic [15:0] rdata);
    int cnt;
    cnt = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    forever begin
        @(posedge clk);
        #1;
        if (wb_rsp.ack) break;
        cnt++;
        if (cnt > BUS_TIMEOUT) begin
            $display("Done: errors found");
            $fatal(1, "no Wishbone ack for address %h", adr);
        end
    end
    rdata = wb_rsp.dat;
    // Release after the edge that samples ack
    @(posedge clk);
    #1;
    wb_req = '0;
endtask

task automatic bus_write(input logic [9:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
endtask

task automatic bus_read(input logic [9:0] adr, output logic [15:0] dat);
    bus_cycle(1'b0, adr, 16'd0, dat);
endtask

// Wait for the delayed raster to leave line 0 and come back to 0,0
task automatic wait_frame();
    int cnt;
    cnt = 0;
    forever begin
        @(posedge clk);
        #1;
        if (timing_dly.vdump != 9'd0) break;
        cnt++;
        if (cnt > FRAME_TIMEOUT) begin
            $display("Done: errors found");
            $fatal(1, "raster stuck on line 0");
        end
    end
    cnt = 0;
    forever begin
        @(posedge clk);
        #1;
        if (timing_dly.vdump == 9'd0 && timing_dly.hdump == 9'd0) break;
        cnt++;
        if (cnt > FRAME_TIMEOUT) begin
            $display("Done: errors found");
            $fatal(1, "frame end never reached");
        end
    end
endtask

// Random PROM image, mirrored in prom_ref
task automatic fill_proms();
    logic [31:0] val;
    for (int c = 0; c < 3; c++) begin
        for (int a = 0; a < 256; a++) begin
            val = $random(seed);
            prom_ref[c][a] = val[3:0];
            bus_write({c[1:0], a[7:0]}, {12'd0, val[3:0]});
        end
    end
endtask

initial begin
    seed        = 32'hac1b;
    prom_loaded = 1'b0;
    wb_req      = '0;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    fill_proms();
    prom_loaded = 1'b1;

    // Frame 1 setup
    bus_write(`VIDEO_WB_PAL, 16'd3);
    bus_write(`VIDEO_WB_OBJX, 16'd40);
    bus_write(`VIDEO_WB_OBJY, 16'd60);
    bus_read(`VIDEO_WB_PAL, rd_val);
    bus_read(`VIDEO_WB_STATUS, rd_val);
    wait_frame();

    // Frame 2, new palette and object spot
    bus_write(`VIDEO_WB_PAL, 16'd5);
    bus_write(`VIDEO_WB_OBJX, 16'd150);
    bus_write(`VIDEO_WB_OBJY, 16'd130);
    bus_read(`VIDEO_WB_PAL, rd_val);
    for (int i = 0; i < 6; i++) begin
        repeat ($unsigned($random(seed)) % 5000) @(posedge clk);
        #1;
        bus_read(`VIDEO_WB_STATUS, rd_val);
    end
    wait_frame();

    if (i_dut.i_chk.err_count == 0) begin
        $display("Done: no errors");
        $finish;
    end else begin
        $display("Done: errors found");
        $fatal(1, "checker reported errors");
    end
end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/video_pkg.sv
verilog/video_timer.sv
verilog/video_layers.sv
verilog/video_colmix.sv
verilog/video_wb_regs.sv
verilog/video_top.sv
tests/video_clkgen.sv
tests/video_assertions.sv
tests/video_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = video_tb
FILELIST = vlog.f
LOG      = sim.log
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
